// File: files.f
txq_pkg.sv
txq_wr_if.sv
txq_rd_if.sv
txq_write_ctrl.sv
txq_loop_buffer.sv
txq_read_sched.sv
txq_framer.sv
txdata_queue.sv
tb_txdata_queue.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the txdata_queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_txdata_queue \
    -f files.f \
    -o sim_txdata_queue

out=$(./obj_dir/sim_txdata_queue)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
else
    exit 1
fi

// File: tb_txdata_queue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_txdata_queue;
    import txq_pkg::*;

    typedef struct {
        string      name;
        int         blocks;
        logic [3:0] ant0;
        logic [7:0] gaps;
        int         hold;
        bit         stall;
    } row_t;

    logic                               i_clk;
    logic                               i_reset;
    logic [ANT_NUM-1:0][SAMPLE_W-1:0]   i_ant_data;
    logic                               i_rx_vld;
    logic [3:0]                         i_ant0_idx;
    logic [3:0]                         i_rbg_idx;
    logic [3:0]                         i_pkg_type;
    logic                               i_cell_idx;
    logic [6:0]                         i_slot_idx;
    logic [3:0]                         i_symb_idx;
    logic [ANT_NUM-1:0][AGC_W-1:0]      i_fft_agc;
    logic [3:0]                         o_rbg_idx;
    logic [3:0]                         o_pkg_type;
    logic                               o_cell_idx;
    logic [6:0]                         o_slot_idx;
    logic [3:0]                         o_symb_idx;
    logic [GRP_ANT-1:0][AGC_W-1:0]      o_fft_agc;
    logic [GRP_ANT-1:0][7:0]            o_pkg_info;
    logic [8:0]                         o_prb_idx;
    logic [GRP_ANT-1:0][SAMPLE_W-1:0]   o_tx_data;
    logic                               o_tx_vld;
    logic                               o_tx_sop;
    logic                               o_tx_eop;
    logic                               o_tready;

    row_t        rows[$];
    logic [127:0] exp_data[$];
    logic [31:0]  exp_agc[$];
    logic [19:0]  exp_fields[$];
    logic [31:0]  exp_tag[$];
    logic [31:0]  lcg_state = 32'd31613;
    string        cur_name = "reset";
    int           errors = 0;
    int           checks = 0;
    int           out_cnt = 0;
    int           total_out_beats = 0;
    bit           table_loaded = 1'b0;
    bit           stall_seen = 1'b0;

    txdata_queue u_txdata_queue (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_value(input string what, input logic [127:0] exp,
                                 input logic [127:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
        end
    endtask

    task automatic add_row(input string name, input int blocks, input logic [3:0] ant0,
                           input logic [7:0] gaps, input int hold, input bit stall);
        row_t r;
        r.name   = name;
        r.blocks = blocks;
        r.ant0   = ant0;
        r.gaps   = gaps;
        r.hold   = hold;
        r.stall  = stall;
        rows.push_back(r);
        total_out_beats += blocks * BLOCK_LEN * GRP_NUM;
    endtask

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    // Gap bit b%8 set puts an idle cycle before beat b, hold is the
    // number of leading blocks sent without gaps
    task automatic load_table();
        add_row("single_block", 1, 4'd0, 8'h00, 0, 1'b0);
        add_row("sparse_gaps", 3, 4'd5, 8'hA6, 0, 1'b0);
        add_row("back_to_back", 10, 4'd14, 8'h00, 10, 1'b1);
        add_row("prb_wrap", 20, 4'd15, 8'h11, 4, 1'b1);
        add_row("tail_gaps", 2, 4'd9, 8'hC3, 0, 1'b0);
        table_loaded = 1'b1;
    endtask

    task automatic send_block(input logic [7:0] gaps, input bit gapped, input logic [3:0] ant0);
        logic [ANT_NUM-1:0][SAMPLE_W-1:0] blk_data [BLOCK_LEN];
        logic [ANT_NUM-1:0][AGC_W-1:0]    blk_agc [BLOCK_LEN];
        logic [19:0]                      blk_fields [BLOCK_LEN];
        logic [GRP_ANT-1:0][SAMPLE_W-1:0] gdata;
        logic [GRP_ANT-1:0][AGC_W-1:0]    gagc;
        logic [GRP_ANT-1:0][7:0]          gtag;
        logic [31:0]                      word;
        for (int b = 0; b < BLOCK_LEN; b++) begin
            @(posedge i_clk);
            #10;
            if (gapped && gaps[3'(b)]) begin
                i_rx_vld = 1'b0;
                @(posedge i_clk);
                #10;
            end
            // A block may only start while the queue has room
            while (b == 0 && !o_tready) begin
                i_rx_vld = 1'b0;
                @(posedge i_clk);
                #10;
            end
            for (int a = 0; a < ANT_NUM; a++) begin
                blk_data[b][a] = lcg_next();
            end
            word = lcg_next();
            blk_agc[b][3:0] = word;
            word = lcg_next();
            blk_agc[b][7:4] = word;
            word = lcg_next();
            blk_fields[b] = word[19:0];
            i_ant_data = blk_data[b];
            i_fft_agc  = blk_agc[b];
            {i_rbg_idx, i_pkg_type, i_cell_idx, i_slot_idx, i_symb_idx} = blk_fields[b];
            i_rx_vld = 1'b1;
        end
        // Even antennas first, then odd, lowest antenna in slot 0
        for (int g = 0; g < GRP_NUM; g++) begin
            for (int b = 0; b < BLOCK_LEN; b++) begin
                for (int j = 0; j < GRP_ANT; j++) begin
                    gdata[j] = blk_data[b][2 * j + g];
                    gagc[j]  = blk_agc[b][2 * j + g];
                    gtag[j]  = {4'(g), ant0 + 4'(2 * j + g)};
                end
                exp_data.push_back(gdata);
                exp_agc.push_back(gagc);
                exp_fields.push_back(blk_fields[b]);
                exp_tag.push_back(gtag);
            end
        end
    endtask

    task automatic run_row(input int r);
        cur_name   = rows[r].name;
        i_ant0_idx = rows[r].ant0;
        stall_seen = 1'b0;
        for (int k = 0; k < rows[r].blocks; k++) begin
            send_block(rows[r].gaps, k >= rows[r].hold, rows[r].ant0);
        end
        @(posedge i_clk);
        #10;
        i_rx_vld = 1'b0;
        while (exp_data.size() != 0) begin
            @(posedge i_clk);
        end
        repeat (8) @(posedge i_clk);
        #10;
        compare_value("tready_idle", 128'(1'b1), 128'(o_tready));
        if (rows[r].stall) begin
            compare_value("tready_stall", 128'(1'b1), 128'(stall_seen));
        end
    endtask

    // ------------------------------------------------------------
    // Output monitor and scoreboard
    // ------------------------------------------------------------
    always @(negedge i_clk) begin
        if (!i_reset) begin
            if (!o_tready) begin
                stall_seen = 1'b1;
            end
            if (o_tx_vld) begin
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("Output beat %0d in %s arrived with no beat expected",
                             out_cnt, cur_name);
                end else begin
                    compare_value("data", exp_data.pop_front(), 128'(o_tx_data));
                    compare_value("fft_agc", 128'(exp_agc.pop_front()), 128'(o_fft_agc));
                    compare_value("fields", 128'(exp_fields.pop_front()),
                                  128'({o_rbg_idx, o_pkg_type, o_cell_idx, o_slot_idx,
                                        o_symb_idx}));
                    compare_value("pkg_info", 128'(exp_tag.pop_front()), 128'(o_pkg_info));
                end
                compare_value("sop", 128'(out_cnt % (RE_PER_RB * RB_PER_PKT) == 0),
                              128'(o_tx_sop));
                compare_value("eop", 128'(out_cnt % RE_PER_RB == RE_PER_RB - 1),
                              128'(o_tx_eop));
                compare_value("prb_idx", 128'((out_cnt / RE_PER_RB) % (PRB_MAX + 1)),
                              128'(o_prb_idx));
                out_cnt++;
            end else begin
                compare_value("sop_idle", 128'(1'b0), 128'(o_tx_sop));
                compare_value("eop_idle", 128'(1'b0), 128'(o_tx_eop));
            end
        end
    end

    // Four cycles per output beat covers stalls and read latency
    initial begin
        longint limit_ns;
        wait (table_loaded);
        limit_ns = 64'(total_out_beats) * 4 * 100 + 20000;
        #(limit_ns);
        $display("Timeout: the output did not drain within %0d ns", limit_ns);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        i_reset    = 1'b1;
        i_rx_vld   = 1'b0;
        i_ant_data = '0;
        i_fft_agc  = '0;
        i_ant0_idx = 4'd0;
        i_rbg_idx  = 4'd0;
        i_pkg_type = 4'd0;
        i_cell_idx = 1'b0;
        i_slot_idx = 7'd0;
        i_symb_idx = 4'd0;
        load_table();
        repeat (3) @(posedge i_clk);
        #10;
        i_reset = 1'b0;
        @(negedge i_clk);
        compare_value("reset_vld", 128'(1'b0), 128'(o_tx_vld));
        compare_value("reset_sop", 128'(1'b0), 128'(o_tx_sop));
        compare_value("reset_eop", 128'(1'b0), 128'(o_tx_eop));
        compare_value("reset_prb", 128'(0), 128'(o_prb_idx));
        compare_value("reset_tready", 128'(1'b1), 128'(o_tready));
        for (int r = 0; r < rows.size(); r++) begin
            run_row(r);
        end
        $display("Checks: %0d, output beats: %0d, errors: %0d", checks, out_cnt, errors);
        if (errors == 0 && exp_data.size() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: txdata_queue.sv
`timescale 1ns/100ps
`default_nettype none

module txdata_queue (
    input  wire                                                 i_clk,
    input  wire                                                 i_reset,
    input  wire [txq_pkg::ANT_NUM-1:0][txq_pkg::SAMPLE_W-1:0]   i_ant_data,
    input  wire                                                 i_rx_vld,
    input  wire [3:0]                                           i_ant0_idx,
    input  wire [3:0]                                           i_rbg_idx,
    input  wire [3:0]                                           i_pkg_type,
    input  wire                                                 i_cell_idx,
    input  wire [6:0]                                           i_slot_idx,
    input  wire [3:0]                                           i_symb_idx,
    input  wire [txq_pkg::ANT_NUM-1:0][txq_pkg::AGC_W-1:0]      i_fft_agc,
    output logic [3:0]                                          o_rbg_idx,
    output logic [3:0]                                          o_pkg_type,
    output logic                                                o_cell_idx,
    output logic [6:0]                                          o_slot_idx,
    output logic [3:0]                                          o_symb_idx,
    output logic [txq_pkg::GRP_ANT-1:0][txq_pkg::AGC_W-1:0]     o_fft_agc,
    output logic [txq_pkg::GRP_ANT-1:0][7:0]                    o_pkg_info,
    output logic [8:0]                                          o_prb_idx,
    output logic [txq_pkg::GRP_ANT-1:0][txq_pkg::SAMPLE_W-1:0]  o_tx_data,
    output logic                                                o_tx_vld,
    output logic                                                o_tx_sop,
    output logic                                                o_tx_eop,
    output logic                                                o_tready
);

    // Shared write port, one read port per group
    txq_wr_if u_wr_if ();
    txq_rd_if u_rd_if0 ();
    txq_rd_if u_rd_if1 ();

    txq_write_ctrl u_write_ctrl (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_ant_data (i_ant_data),
        .i_rx_vld   (i_rx_vld),
        .i_fft_agc  (i_fft_agc),
        .i_rbg_idx  (i_rbg_idx),
        .i_pkg_type (i_pkg_type),
        .i_cell_idx (i_cell_idx),
        .i_slot_idx (i_slot_idx),
        .i_symb_idx (i_symb_idx),
        .wr         (u_wr_if.writer),
        .o_tready   (o_tready)
    );

    // ------------------------------------------------------------
    // Group buffers, even and odd antennas
    // ------------------------------------------------------------
    txq_loop_buffer #(
        .GRP_IDX (0)
    ) u_loop_buffer0 (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .wr      (u_wr_if.buffer),
        .rd      (u_rd_if0.buffer)
    );

    txq_loop_buffer #(
        .GRP_IDX (1)
    ) u_loop_buffer1 (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .wr      (u_wr_if.buffer),
        .rd      (u_rd_if1.buffer)
    );

    txq_read_sched u_read_sched (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .rd0        (u_rd_if0.reader),
        .rd1        (u_rd_if1.reader),
        .i_ant0_idx (i_ant0_idx),
        .o_tx_data  (o_tx_data),
        .o_tx_vld   (o_tx_vld),
        .o_fft_agc  (o_fft_agc),
        .o_rbg_idx  (o_rbg_idx),
        .o_pkg_type (o_pkg_type),
        .o_cell_idx (o_cell_idx),
        .o_slot_idx (o_slot_idx),
        .o_symb_idx (o_symb_idx),
        .o_pkg_info (o_pkg_info)
    );

    txq_framer u_framer (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_tx_vld  (o_tx_vld),
        .o_tx_sop  (o_tx_sop),
        .o_tx_eop  (o_tx_eop),
        .o_prb_idx (o_prb_idx)
    );

endmodule

`default_nettype wire

// File: txq_framer.sv
`timescale 1ns/100ps
`default_nettype none

module txq_framer (
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_tx_vld,
    output logic       o_tx_sop,
    output logic       o_tx_eop,
    output logic [8:0] o_prb_idx
);
    import txq_pkg::*;

    localparam int RE_W = $clog2(RE_PER_RB);
    localparam int RB_W = $clog2(RB_PER_PKT);

    logic [RE_W-1:0] re_cnt;
    logic [RB_W-1:0] rb_cnt;

    // Flags from the counters, aligned with the beat
    assign o_tx_eop = i_tx_vld && (re_cnt == RE_W'(RE_PER_RB - 1));
    assign o_tx_sop = i_tx_vld && (re_cnt == '0) && (rb_cnt == '0);

    // ------------------------------------------------------------
    // RE and RB counters
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt <= '0;
        end else if (o_tx_eop) begin
            re_cnt <= '0;
        end else if (i_tx_vld) begin
            re_cnt <= re_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rb_cnt <= '0;
        end else if (o_tx_eop) begin
            if (rb_cnt == RB_W'(RB_PER_PKT - 1)) begin
                rb_cnt <= '0;
            end else begin
                rb_cnt <= rb_cnt + 1'b1;
            end
        end
    end

    // PRB index, one step per RB
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_prb_idx <= '0;
        end else if (o_tx_eop) begin
            if (o_prb_idx == 9'(PRB_MAX)) begin
                o_prb_idx <= '0;
            end else begin
                o_prb_idx <= o_prb_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: txq_read_sched.sv
`timescale 1ns/100ps
`default_nettype none

module txq_read_sched (
    input  wire                                                 i_clk,
    input  wire                                                 i_reset,
    txq_rd_if.reader                                            rd0,
    txq_rd_if.reader                                            rd1,
    input  wire [3:0]                                           i_ant0_idx,
    output logic [txq_pkg::GRP_ANT-1:0][txq_pkg::SAMPLE_W-1:0]  o_tx_data,
    output logic                                                o_tx_vld,
    output logic [txq_pkg::GRP_ANT-1:0][txq_pkg::AGC_W-1:0]     o_fft_agc,
    output logic [3:0]                                          o_rbg_idx,
    output logic [3:0]                                          o_pkg_type,
    output logic                                                o_cell_idx,
    output logic [6:0]                                          o_slot_idx,
    output logic [3:0]                                          o_symb_idx,
    output logic [txq_pkg::GRP_ANT-1:0][7:0]                    o_pkg_info
);
    import txq_pkg::*;

    logic              grp;
    logic              ren_q;
    logic [ADDR_W-1:0] raddr;
    logic              rlast;
    logic              cur_avail;
    logic [RD_LAT-1:0] vld_sr;
    logic [RD_LAT-1:0] sel_sr;
    logic              sel;
    dinfo_u            info_q;

    // ------------------------------------------------------------
    // Group alternation and read addressing
    // ------------------------------------------------------------
    assign cur_avail = grp ? rd1.avail : rd0.avail;
    assign rlast     = ren_q && (raddr == ADDR_W'(BLOCK_LEN - 1));

    assign rd0.ren   = ren_q && !grp;
    assign rd1.ren   = ren_q && grp;
    assign rd0.raddr = raddr;
    assign rd1.raddr = raddr;
    assign rd0.rlast = rlast && !grp;
    assign rd1.rlast = rlast && grp;

    // A started block is complete, so no avail check until its end
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            grp   <= 1'b0;
            ren_q <= 1'b0;
            raddr <= '0;
        end else if (rlast) begin
            grp   <= ~grp;
            ren_q <= 1'b0;
            raddr <= '0;
        end else if (ren_q) begin
            raddr <= raddr + 1'b1;
        end else begin
            ren_q <= cur_avail;
        end
    end

    // ------------------------------------------------------------
    // Group select follows the RAM latency
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            vld_sr <= '0;
        end else begin
            vld_sr[0] <= ren_q;
            for (int i = 1; i < RD_LAT; i++) begin
                vld_sr[i] <= vld_sr[i-1];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        sel_sr[0] <= grp;
        for (int i = 1; i < RD_LAT; i++) begin
            sel_sr[i] <= sel_sr[i-1];
        end
    end

    assign sel = sel_sr[RD_LAT-1];

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_tx_vld <= 1'b0;
        end else begin
            o_tx_vld <= vld_sr[RD_LAT-1];
        end
    end

    always_ff @(posedge i_clk) begin
        o_tx_data <= sel ? rd1.rdata : rd0.rdata;
        info_q    <= sel ? rd1.rinfo : rd0.rinfo;
        // Group in upper nibble, antenna number mod 16 in lower
        for (int j = 0; j < GRP_ANT; j++) begin
            o_pkg_info[j] <= {3'b000, sel, i_ant0_idx + 4'(2 * j) + {3'b000, sel}};
        end
    end

    assign o_fft_agc  = info_q.f.fft_agc;
    assign o_rbg_idx  = info_q.f.rbg_idx;
    assign o_pkg_type = info_q.f.pkg_type;
    assign o_cell_idx = info_q.f.cell_idx;
    assign o_slot_idx = info_q.f.slot_idx;
    assign o_symb_idx = info_q.f.symb_idx;

endmodule

`default_nettype wire

// File: txq_loop_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module txq_loop_buffer #(
    parameter int GRP_IDX = 0
) (
    input  wire       i_clk,
    input  wire       i_reset,
    txq_wr_if.buffer  wr,
    txq_rd_if.buffer  rd
);
    import txq_pkg::*;

    localparam int DEPTH  = BLOCK_NUM * BLOCK_LEN;
    localparam int RAM_AW = $clog2(DEPTH);
    localparam int BLK_W  = $clog2(BLOCK_NUM);
    localparam int DATA_W = GRP_ANT * SAMPLE_W;
    localparam int WORD_W = DATA_W + DINFO_W;

    logic [WORD_W-1:0]    ram [DEPTH];
    logic [WORD_W-1:0]    rd_word;
    logic [BLOCK_NUM-1:0] filled;
    logic [BLK_W-1:0]     wblk;
    logic [BLK_W-1:0]     rblk;
    logic [RAM_AW-1:0]    waddr;
    logic [RAM_AW-1:0]    raddr;

    assign waddr = RAM_AW'(wblk) * RAM_AW'(BLOCK_LEN) + RAM_AW'(wr.addr);
    assign raddr = RAM_AW'(rblk) * RAM_AW'(BLOCK_LEN) + RAM_AW'(rd.raddr);

    // ------------------------------------------------------------
    // RAM, data above raw descriptor
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (wr.wen) begin
            ram[waddr] <= {wr.data[GRP_IDX], wr.info[GRP_IDX].raw};
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd.ren) begin
            rd_word <= ram[raddr];
        end
    end

    assign rd.rdata     = rd_word[WORD_W-1:DINFO_W];
    assign rd.rinfo.raw = rd_word[DINFO_W-1:0];

    // ------------------------------------------------------------
    // Block tracking
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            filled <= '0;
            wblk   <= '0;
            rblk   <= '0;
        end else begin
            if (wr.wlast) begin
                filled[wblk] <= 1'b1;
                wblk         <= wblk + 1'b1;
            end
            // Never the block being written
            if (rd.rlast) begin
                filled[rblk] <= 1'b0;
                rblk         <= rblk + 1'b1;
            end
        end
    end

    assign rd.avail = filled[rblk];

    // Counts the block that completes this cycle, so a source
    // checking tready on the next cycle sees it already
    assign wr.full[GRP_IDX] = filled[wblk + 1'b1] && (filled[wblk] || wr.wlast);

endmodule

`default_nettype wire

// File: txq_write_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module txq_write_ctrl (
    input  wire                                                 i_clk,
    input  wire                                                 i_reset,
    input  wire [txq_pkg::ANT_NUM-1:0][txq_pkg::SAMPLE_W-1:0]   i_ant_data,
    input  wire                                                 i_rx_vld,
    input  wire [txq_pkg::ANT_NUM-1:0][txq_pkg::AGC_W-1:0]      i_fft_agc,
    input  wire [3:0]                                           i_rbg_idx,
    input  wire [3:0]                                           i_pkg_type,
    input  wire                                                 i_cell_idx,
    input  wire [6:0]                                           i_slot_idx,
    input  wire [3:0]                                           i_symb_idx,
    txq_wr_if.writer                                            wr,
    output logic                                                o_tready
);
    import txq_pkg::*;

    logic [GRP_NUM-1:0][GRP_ANT-1:0][SAMPLE_W-1:0] grp_data;
    dinfo_u [GRP_NUM-1:0]                          grp_info;

    // ------------------------------------------------------------
    // Group split
    // ------------------------------------------------------------
    // Group g takes antennas g, g+2, g+4, g+6, lowest in slot 0
    always_comb begin
        for (int g = 0; g < GRP_NUM; g++) begin
            for (int j = 0; j < GRP_ANT; j++) begin
                grp_data[g][j]           = i_ant_data[GRP_NUM * j + g];
                grp_info[g].f.fft_agc[j] = i_fft_agc[GRP_NUM * j + g];
            end
            grp_info[g].f.rbg_idx  = i_rbg_idx;
            grp_info[g].f.pkg_type = i_pkg_type;
            grp_info[g].f.cell_idx = i_cell_idx;
            grp_info[g].f.slot_idx = i_slot_idx;
            grp_info[g].f.symb_idx = i_symb_idx;
        end
    end

    always_ff @(posedge i_clk) begin
        wr.data <= grp_data;
        wr.info <= grp_info;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr.wen <= 1'b0;
        end else begin
            wr.wen <= i_rx_vld;
        end
    end

    // ------------------------------------------------------------
    // Write address
    // ------------------------------------------------------------
    assign wr.wlast = wr.wen && (wr.addr == ADDR_W'(BLOCK_LEN - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr.addr <= '0;
        end else if (wr.wlast) begin
            wr.addr <= '0;
        end else if (wr.wen) begin
            wr.addr <= wr.addr + 1'b1;
        end
    end

    // Source holds off new blocks while any group buffer is full
    assign o_tready = ~|wr.full;

endmodule

`default_nettype wire

// File: txq_rd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface txq_rd_if;
    import txq_pkg::*;

    logic                             ren;
    logic [ADDR_W-1:0]                raddr;
    // Goes with the last read of a block and frees it
    logic                             rlast;
    logic [GRP_ANT-1:0][SAMPLE_W-1:0] rdata;
    dinfo_u                           rinfo;
    logic                             avail;

    modport reader (
        output ren, raddr, rlast,
        input  rdata, rinfo, avail
    );

    modport buffer (
        input  ren, raddr, rlast,
        output rdata, rinfo, avail
    );

endinterface

`default_nettype wire

// File: txq_wr_if.sv
`timescale 1ns/100ps
`default_nettype none

interface txq_wr_if;
    import txq_pkg::*;

    logic                                          wen;
    logic [ADDR_W-1:0]                             addr;
    // Final beat of a block, already qualified by wen
    logic                                          wlast;
    logic [GRP_NUM-1:0][GRP_ANT-1:0][SAMPLE_W-1:0] data;
    dinfo_u [GRP_NUM-1:0]                          info;
    // One bit per group buffer
    logic [GRP_NUM-1:0]                            full;

    modport writer (
        output wen, addr, wlast, data, info,
        input  full
    );

    modport buffer (
        input  wen, addr, wlast, data, info,
        output full
    );

endinterface

`default_nettype wire

// File: txq_pkg.sv
`default_nettype none

package txq_pkg;

    // ------------------------------------------------------------
    // Stream and buffer sizes
    // ------------------------------------------------------------
    localparam int ANT_NUM  = 8;
    localparam int GRP_NUM  = 2;
    localparam int GRP_ANT  = ANT_NUM / GRP_NUM;
    localparam int SAMPLE_W = 32;
    localparam int AGC_W    = 8;

    // 4 RBs of 12 REs per block
    localparam int BLOCK_LEN = 48;
    localparam int BLOCK_NUM = 2;
    localparam int ADDR_W    = $clog2(BLOCK_LEN);

    // Framing
    localparam int RE_PER_RB  = 12;
    localparam int RB_PER_PKT = 4;
    localparam int PRB_MAX    = 131;

    localparam int DINFO_W = 52;
    localparam int RD_LAT  = 1;

    // ------------------------------------------------------------
    // Symbol descriptor
    // ------------------------------------------------------------
    typedef struct packed {
        logic [GRP_ANT-1:0][AGC_W-1:0] fft_agc;
        logic [3:0]                    rbg_idx;
        logic [3:0]                    pkg_type;
        logic                          cell_idx;
        logic [6:0]                    slot_idx;
        logic [3:0]                    symb_idx;
    } dinfo_f_t;

    // Raw word goes into RAM, field view on both ends
    typedef union packed {
        logic [DINFO_W-1:0] raw;
        dinfo_f_t           f;
    } dinfo_u;

endpackage

`default_nettype wire
